/* isa_pkg.sv */
// Instruction-set package with opcodes, field positions, widths and memory depths
`default_nettype none

package isa_pkg;

  // Datapath and register file
  localparam int data_w     = 16;
  localparam int reg_addr_w = 3;
  localparam int num_regs   = 2 ** reg_addr_w;

  // Word-addressed memories
  localparam int imem_depth  = 256;
  localparam int imem_addr_w = 8;
  localparam int dmem_depth  = 256;
  localparam int dmem_addr_w = 8;

  // Instruction fields
  // R type:  op rs rt rd  (rd = rs op rt)
  // I type:  op rs rt imm5  (addi and ld write rt, st stores rt)
  // B type:  op rs disp8  (beqz tests rs, j ignores it)
  localparam int op_msb    = 15;
  localparam int op_lsb    = 11;
  localparam int rs_msb    = 10;
  localparam int rs_lsb    = 8;
  localparam int rt_msb    = 7;
  localparam int rt_lsb    = 5;
  localparam int rd_msb    = 4;
  localparam int rd_lsb    = 2;
  localparam int imm5_msb  = 4;
  localparam int imm5_lsb  = 0;
  localparam int imm5_w    = imm5_msb - imm5_lsb + 1;
  localparam int disp8_msb = 7;
  localparam int disp8_lsb = 0;
  localparam int disp8_w   = disp8_msb - disp8_lsb + 1;

  // Codes not listed here are illegal
  typedef enum logic [4:0] {
    op_nop  = 5'd0,
    op_halt = 5'd1,
    op_add  = 5'd2,
    op_sub  = 5'd3,
    op_and  = 5'd4,
    op_xor  = 5'd5,
    op_addi = 5'd6,
    op_ld   = 5'd7,
    op_st   = 5'd8,
    op_beqz = 5'd9,
    op_j    = 5'd10
  } opcode_t;

endpackage

`default_nettype wire

/* pipe_pkg.sv */
// Pipeline latch structs and the ALU operation enum passed between the stages
`default_nettype none

package pipe_pkg;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_xor,
    alu_pass_b
  } alu_op_t;

  typedef struct packed {
    logic                       valid;
    logic [isa_pkg::data_w-1:0] instr;
    logic [isa_pkg::data_w-1:0] pc_plus_one;
  } if_id_t;

  typedef struct packed {
    logic                           valid;
    isa_pkg::opcode_t               opcode;
    alu_op_t                        alu_op;
    logic [isa_pkg::data_w-1:0]     a;
    logic [isa_pkg::data_w-1:0]     b;
    // imm5 or disp8, already sign-extended
    logic [isa_pkg::data_w-1:0]     imm;
    logic                           use_imm;
    logic                           mem_read;
    logic                           mem_write;
    logic                           reg_write;
    logic                           is_branch;
    logic [isa_pkg::reg_addr_w-1:0] dest;
    logic [isa_pkg::data_w-1:0]     pc_plus_one;
  } id_ex_t;

  typedef struct packed {
    logic                           valid;
    logic [isa_pkg::data_w-1:0]     result;
    logic [isa_pkg::data_w-1:0]     store_data;
    logic                           mem_read;
    logic                           mem_write;
    logic                           reg_write;
    logic                           is_halt;
    logic [isa_pkg::reg_addr_w-1:0] dest;
  } ex_mem_t;

  typedef struct packed {
    logic                           valid;
    logic                           reg_write;
    logic                           is_halt;
    logic [isa_pkg::reg_addr_w-1:0] dest;
    logic [isa_pkg::data_w-1:0]     wdata;
  } mem_wb_t;

endpackage

`default_nettype wire

/* fetch.sv */
// Fetch stage with PC, loadable instruction RAM and the IF/ID latch
`timescale 1ns/1ps
`default_nettype none

module fetch (
  input  wire                             clk,
  input  wire                             reset,
  input  wire                             imem_we,
  input  wire [isa_pkg::imem_addr_w-1:0]  imem_addr,
  input  wire [isa_pkg::data_w-1:0]       imem_data,
  input  wire                             stall,
  input  wire                             halted,
  input  wire                             redirect,
  input  wire [isa_pkg::data_w-1:0]       redirect_pc,
  output pipe_pkg::if_id_t                if_id
);

  logic [isa_pkg::data_w-1:0] imem [isa_pkg::imem_depth];
  logic [isa_pkg::data_w-1:0] pc;
  logic [isa_pkg::data_w-1:0] pc_plus_one;
  logic [isa_pkg::data_w-1:0] instr;
  logic                       running;

  // Program load port, only open while reset is held
  always_ff @(posedge clk) begin
    if (reset && imem_we)
      imem[imem_addr] <= imem_data;
  end

  assign instr       = imem[pc[isa_pkg::imem_addr_w-1:0]];
  assign pc_plus_one = pc + isa_pkg::data_w'(1);

  // Issue starts one cycle after reset release
  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      running     <= 1'b0;
      if_id.valid <= 1'b0;
    end else begin
      running <= 1'b1;
      if (redirect) begin
        pc          <= redirect_pc;
        if_id.valid <= 1'b0;
      end else if (!stall) begin
        if (running && !halted) begin
          pc          <= pc_plus_one;
          if_id.valid <= 1'b1;
        end else begin
          if_id.valid <= 1'b0;
        end
      end
    end
    if (!stall) begin
      if_id.instr       <= instr;
      if_id.pc_plus_one <= pc_plus_one;
    end
  end

endmodule

`default_nettype wire

/* decode.sv */
// Decode stage with control decode, register file with write bypass and the ID/EX latch
`timescale 1ns/1ps
`default_nettype none

module decode (
  input  wire                             clk,
  input  wire                             reset,
  input  wire pipe_pkg::if_id_t           if_id,
  input  wire                             stall,
  input  wire                             redirect,
  input  wire pipe_pkg::mem_wb_t          wb,
  output pipe_pkg::id_ex_t                id_ex,
  output logic                            rs_used,
  output logic                            rt_used,
  output logic [isa_pkg::reg_addr_w-1:0]  rs_addr,
  output logic [isa_pkg::reg_addr_w-1:0]  rt_addr
);

  isa_pkg::opcode_t               opcode;
  logic [isa_pkg::reg_addr_w-1:0] rd_addr;
  logic [isa_pkg::data_w-1:0]     imm5_ext;
  logic [isa_pkg::data_w-1:0]     disp8_ext;
  pipe_pkg::alu_op_t              alu_op;
  logic                           use_imm;
  logic                           use_disp;
  logic                           mem_read;
  logic                           mem_write;
  logic                           reg_write;
  logic                           is_branch;
  logic                           dest_is_rt;
  logic                           uses_rs;
  logic                           uses_rt;
  logic [isa_pkg::data_w-1:0]     regs [isa_pkg::num_regs];
  logic [isa_pkg::data_w-1:0]     rs_val;
  logic [isa_pkg::data_w-1:0]     rt_val;
  logic                           wb_write;
  logic                           halt_seen;
  logic                           issue;

  assign opcode  = isa_pkg::opcode_t'(if_id.instr[isa_pkg::op_msb:isa_pkg::op_lsb]);
  assign rs_addr = if_id.instr[isa_pkg::rs_msb:isa_pkg::rs_lsb];
  assign rt_addr = if_id.instr[isa_pkg::rt_msb:isa_pkg::rt_lsb];
  assign rd_addr = if_id.instr[isa_pkg::rd_msb:isa_pkg::rd_lsb];

  assign imm5_ext  = {{(isa_pkg::data_w - isa_pkg::imm5_w){if_id.instr[isa_pkg::imm5_msb]}},
                      if_id.instr[isa_pkg::imm5_msb:isa_pkg::imm5_lsb]};
  assign disp8_ext = {{(isa_pkg::data_w - isa_pkg::disp8_w){if_id.instr[isa_pkg::disp8_msb]}},
                      if_id.instr[isa_pkg::disp8_msb:isa_pkg::disp8_lsb]};

  always_comb begin
    alu_op     = pipe_pkg::alu_pass_b;
    use_imm    = 1'b0;
    use_disp   = 1'b0;
    mem_read   = 1'b0;
    mem_write  = 1'b0;
    reg_write  = 1'b0;
    is_branch  = 1'b0;
    dest_is_rt = 1'b0;
    uses_rs    = 1'b0;
    uses_rt    = 1'b0;
    case (opcode)
      isa_pkg::op_add, isa_pkg::op_sub, isa_pkg::op_and, isa_pkg::op_xor: begin
        alu_op    = (opcode == isa_pkg::op_add) ? pipe_pkg::alu_add :
                    (opcode == isa_pkg::op_sub) ? pipe_pkg::alu_sub :
                    (opcode == isa_pkg::op_and) ? pipe_pkg::alu_and : pipe_pkg::alu_xor;
        reg_write = 1'b1;
        uses_rs   = 1'b1;
        uses_rt   = 1'b1;
      end
      isa_pkg::op_addi, isa_pkg::op_ld: begin
        alu_op     = pipe_pkg::alu_add;
        use_imm    = 1'b1;
        mem_read   = (opcode == isa_pkg::op_ld);
        reg_write  = 1'b1;
        dest_is_rt = 1'b1;
        uses_rs    = 1'b1;
      end
      isa_pkg::op_st: begin
        alu_op    = pipe_pkg::alu_add;
        use_imm   = 1'b1;
        mem_write = 1'b1;
        uses_rs   = 1'b1;
        uses_rt   = 1'b1;
      end
      isa_pkg::op_beqz, isa_pkg::op_j: begin
        use_disp  = 1'b1;
        is_branch = 1'b1;
        uses_rs   = (opcode == isa_pkg::op_beqz);
      end
      // nop, halt and illegal codes carry no control
      default: ;
    endcase
  end

  assign rs_used = if_id.valid & uses_rs;
  assign rt_used = if_id.valid & uses_rt;

  // Register zero is never written, so it always reads zero
  assign wb_write = wb.valid & wb.reg_write & (wb.dest != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < isa_pkg::num_regs; i++)
        regs[i] <= '0;
    end else if (wb_write) begin
      regs[wb.dest] <= wb.wdata;
    end
  end

  // Same-cycle write is seen by the read
  always_comb begin
    rs_val = regs[rs_addr];
    rt_val = regs[rt_addr];
    if (wb_write && (wb.dest == rs_addr))
      rs_val = wb.wdata;
    if (wb_write && (wb.dest == rt_addr))
      rt_val = wb.wdata;
  end

  // Nothing younger than a halt is issued
  assign issue = if_id.valid & ~stall & ~redirect & ~halt_seen;

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex.valid <= 1'b0;
      halt_seen   <= 1'b0;
    end else begin
      id_ex.valid <= issue;
      if (issue && (opcode == isa_pkg::op_halt))
        halt_seen <= 1'b1;
    end
    id_ex.opcode      <= opcode;
    id_ex.alu_op      <= alu_op;
    id_ex.a           <= rs_val;
    id_ex.b           <= rt_val;
    id_ex.imm         <= use_disp ? disp8_ext : imm5_ext;
    id_ex.use_imm     <= use_imm;
    id_ex.mem_read    <= mem_read;
    id_ex.mem_write   <= mem_write;
    id_ex.reg_write   <= reg_write;
    id_ex.is_branch   <= is_branch;
    id_ex.dest        <= dest_is_rt ? rt_addr : rd_addr;
    id_ex.pc_plus_one <= if_id.pc_plus_one;
  end

endmodule

`default_nettype wire

/* hazard_detection.sv */
// Stall generation from source registers in decode against pending writes in ID/EX and EX/MEM
`timescale 1ns/1ps
`default_nettype none

module hazard_detection (
  input  wire                             rs_used,
  input  wire                             rt_used,
  input  wire [isa_pkg::reg_addr_w-1:0]   rs_addr,
  input  wire [isa_pkg::reg_addr_w-1:0]   rt_addr,
  input  wire pipe_pkg::id_ex_t           id_ex,
  input  wire pipe_pkg::ex_mem_t          ex_mem,
  output logic                            stall
);

  logic idex_wr;
  logic exmem_wr;
  logic rs_hit;
  logic rt_hit;

  // Writers still in flight; MEM/WB is covered by the register file bypass
  assign idex_wr  = id_ex.valid & id_ex.reg_write;
  assign exmem_wr = ex_mem.valid & ex_mem.reg_write;

  assign rs_hit = (idex_wr & (rs_addr == id_ex.dest)) |
                  (exmem_wr & (rs_addr == ex_mem.dest));
  assign rt_hit = (idex_wr & (rt_addr == id_ex.dest)) |
                  (exmem_wr & (rt_addr == ex_mem.dest));

  assign stall = (rs_used & rs_hit) | (rt_used & rt_hit);

endmodule

`default_nettype wire

/* execute.sv */
// Execute stage with ALU, branch resolution, illegal-opcode trap and the EX/MEM latch
`timescale 1ns/1ps
`default_nettype none

module execute (
  input  wire                         clk,
  input  wire                         reset,
  input  wire pipe_pkg::id_ex_t       id_ex,
  output pipe_pkg::ex_mem_t           ex_mem,
  output logic                        redirect,
  output logic [isa_pkg::data_w-1:0]  redirect_pc,
  output logic                        err
);

  logic [isa_pkg::data_w-1:0] b_in;
  logic [isa_pkg::data_w-1:0] alu_y;
  logic                       legal;
  logic                       taken;

  assign b_in = id_ex.use_imm ? id_ex.imm : id_ex.b;

  always_comb begin
    case (id_ex.alu_op)
      pipe_pkg::alu_add: alu_y = id_ex.a + b_in;
      pipe_pkg::alu_sub: alu_y = id_ex.a - b_in;
      pipe_pkg::alu_and: alu_y = id_ex.a & b_in;
      pipe_pkg::alu_xor: alu_y = id_ex.a ^ b_in;
      default:           alu_y = b_in;
    endcase
  end

  always_comb begin
    case (id_ex.opcode)
      isa_pkg::op_nop, isa_pkg::op_halt, isa_pkg::op_add, isa_pkg::op_sub,
      isa_pkg::op_and, isa_pkg::op_xor, isa_pkg::op_addi, isa_pkg::op_ld,
      isa_pkg::op_st, isa_pkg::op_beqz, isa_pkg::op_j:
        legal = 1'b1;
      default:
        legal = 1'b0;
    endcase
  end

  // j always taken, beqz when rs is zero
  assign taken = id_ex.is_branch & ((id_ex.opcode == isa_pkg::op_j) | (id_ex.a == '0));

  assign redirect    = id_ex.valid & legal & taken;
  assign redirect_pc = id_ex.pc_plus_one + id_ex.imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.valid <= 1'b0;
      err          <= 1'b0;
    end else begin
      ex_mem.valid <= id_ex.valid;
      err          <= id_ex.valid & ~legal;
    end
    ex_mem.result     <= alu_y;
    ex_mem.store_data <= id_ex.b;
    // An illegal instruction passes on as a bubble with no side effects
    ex_mem.mem_read   <= id_ex.mem_read & legal;
    ex_mem.mem_write  <= id_ex.mem_write & legal;
    ex_mem.reg_write  <= id_ex.reg_write & legal;
    ex_mem.is_halt    <= (id_ex.opcode == isa_pkg::op_halt);
    ex_mem.dest       <= id_ex.dest;
  end

endmodule

`default_nettype wire

/* memory.sv */
// Memory stage with data RAM, writeback select, MEM/WB latch and the halted flag
`timescale 1ns/1ps
`default_nettype none

module memory (
  input  wire                     clk,
  input  wire                     reset,
  input  wire pipe_pkg::ex_mem_t  ex_mem,
  output pipe_pkg::mem_wb_t       mem_wb,
  output logic                    halted
);

  logic [isa_pkg::data_w-1:0]      dmem [isa_pkg::dmem_depth];
  logic [isa_pkg::dmem_addr_w-1:0] addr;
  logic [isa_pkg::data_w-1:0]      rdata;
  logic [isa_pkg::data_w-1:0]      wdata;
  logic                            halt_q;

  // Word address from the low ALU bits
  assign addr  = ex_mem.result[isa_pkg::dmem_addr_w-1:0];
  assign rdata = dmem[addr];
  assign wdata = ex_mem.mem_read ? rdata : ex_mem.result;

  always_ff @(posedge clk) begin
    if (ex_mem.valid && ex_mem.mem_write)
      dmem[addr] <= ex_mem.store_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb.valid <= 1'b0;
      halt_q       <= 1'b0;
    end else begin
      mem_wb.valid <= ex_mem.valid;
      halt_q       <= halted;
    end
    mem_wb.reg_write <= ex_mem.reg_write;
    mem_wb.is_halt   <= ex_mem.is_halt;
    mem_wb.dest      <= ex_mem.dest;
    mem_wb.wdata     <= wdata;
  end

  // High from the halt's writeback cycle and then held until reset
  assign halted = halt_q | (mem_wb.valid & mem_wb.is_halt);

endmodule

`default_nettype wire

/* proc.sv */
// Top level of the five-stage pipeline, with program load port and retire trace outputs
`timescale 1ns/1ps
`default_nettype none

module proc (
  input  wire                             clk,
  input  wire                             reset,
  input  wire                             imem_we,
  input  wire [isa_pkg::imem_addr_w-1:0]  imem_addr,
  input  wire [isa_pkg::data_w-1:0]       imem_data,
  output logic                            err,
  output logic                            halted,
  output logic                            wb_valid,
  output logic [isa_pkg::reg_addr_w-1:0]  wb_reg,
  output logic [isa_pkg::data_w-1:0]      wb_data
);

  pipe_pkg::if_id_t               if_id;
  pipe_pkg::id_ex_t               id_ex;
  pipe_pkg::ex_mem_t              ex_mem;
  pipe_pkg::mem_wb_t              mem_wb;
  logic                           stall;
  logic                           redirect;
  logic [isa_pkg::data_w-1:0]     redirect_pc;
  logic                           rs_used;
  logic                           rt_used;
  logic [isa_pkg::reg_addr_w-1:0] rs_addr;
  logic [isa_pkg::reg_addr_w-1:0] rt_addr;

  fetch fetch0 (
    .clk(clk), .reset(reset),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
    .stall(stall), .halted(halted),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .if_id(if_id)
  );

  // Register file writes come back from MEM/WB
  decode decode0 (
    .clk(clk), .reset(reset),
    .if_id(if_id), .stall(stall), .redirect(redirect), .wb(mem_wb),
    .id_ex(id_ex),
    .rs_used(rs_used), .rt_used(rt_used), .rs_addr(rs_addr), .rt_addr(rt_addr)
  );

  hazard_detection hd (
    .rs_used(rs_used), .rt_used(rt_used), .rs_addr(rs_addr), .rt_addr(rt_addr),
    .id_ex(id_ex), .ex_mem(ex_mem),
    .stall(stall)
  );

  execute execute0 (
    .clk(clk), .reset(reset),
    .id_ex(id_ex), .ex_mem(ex_mem),
    .redirect(redirect), .redirect_pc(redirect_pc), .err(err)
  );

  memory memory0 (
    .clk(clk), .reset(reset),
    .ex_mem(ex_mem), .mem_wb(mem_wb), .halted(halted)
  );

  // Retire trace, one entry per register write
  assign wb_valid = mem_wb.valid & mem_wb.reg_write;
  assign wb_reg   = mem_wb.dest;
  assign wb_data  = mem_wb.wdata;

endmodule

`default_nettype wire

/* tb_clock.sv */
// Testbench clock source with an 8 ns period, instantiated by the processor testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk
);

  localparam realtime half_period = 4ns;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

endmodule

`default_nettype wire

/* proc_chk.sv */
// Bound checker with concurrent assertions on the processor retire trace and control outputs
`timescale 1ns/1ps
`default_nettype none

module proc_chk (
  input wire        clk,
  input wire        reset,
  input wire        err,
  input wire        halted,
  input wire        wb_valid,
  input wire [2:0]  wb_reg,
  input wire [15:0] wb_data,
  input wire        exp_avail,
  input wire [2:0]  exp_reg,
  input wire [15:0] exp_data,
  input int         exp_errs
);

  int fail_count = 0;
  int err_count;

  always_ff @(posedge clk) begin
    if (reset)
      err_count <= 0;
    else if (err)
      err_count <= err_count + 1;
  end

  // Quiet outputs on every edge that follows a reset edge
  a_reset_quiet: assert property (@(posedge clk) reset |=> !wb_valid && !err && !halted)
    else begin
      $error("Outputs active while reset is held at %0t", $time);
      fail_count++;
    end

  // First instruction of every program is a register write
  a_first_retire: assert property (@(posedge clk)
    $fell(reset) |-> (!wb_valid && !err && !halted) [*5] ##1 wb_valid)
    else begin
      $error("First retire not five edges after reset release at %0t", $time);
      fail_count++;
    end

  a_retire_expected: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> exp_avail)
    else begin
      $error("Retire of r%0d with no write left in the model at %0t", $sampled(wb_reg), $time);
      fail_count++;
    end

  a_retire_reg: assert property (@(posedge clk) disable iff (reset)
    wb_valid && exp_avail |-> wb_reg == exp_reg)
    else begin
      $error("Fail time %0t wb_reg got %0d expected %0d",
             $time, $sampled(wb_reg), $sampled(exp_reg));
      fail_count++;
    end

  a_retire_data: assert property (@(posedge clk) disable iff (reset)
    wb_valid && exp_avail |-> wb_data == exp_data)
    else begin
      $error("Fail time %0t wb_data got %h expected %h",
             $time, $sampled(wb_data), $sampled(exp_data));
      fail_count++;
    end

  a_err_pulse: assert property (@(posedge clk) disable iff (reset) err |=> !err)
    else begin
      $error("err held longer than one cycle at %0t", $time);
      fail_count++;
    end

  a_halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else begin
      $error("halted dropped without reset at %0t", $time);
      fail_count++;
    end

  a_halt_no_retire: assert property (@(posedge clk) disable iff (reset) halted |-> !wb_valid)
    else begin
      $error("Register write retired after halt at %0t", $time);
      fail_count++;
    end

  // All writes done and every illegal opcode trapped by the time halt lands
  a_halt_writes_done: assert property (@(posedge clk) disable iff (reset)
    $rose(halted) |-> !exp_avail)
    else begin
      $error("Halt reached while model writes were still missing at %0t", $time);
      fail_count++;
    end

  a_halt_err_count: assert property (@(posedge clk) disable iff (reset)
    $rose(halted) |-> err_count == exp_errs)
    else begin
      $error("Fail time %0t err_count got %0d expected %0d",
             $time, $sampled(err_count), exp_errs);
      fail_count++;
    end

endmodule

`default_nettype wire

/* tb_proc.sv */
// Processor testbench that loads LFSR-built programs, runs a reference model and ends the run
`timescale 1ns/1ps
`default_nettype none

module tb_proc;

  localparam int alu_len   = 32;
  localparam int mem_len   = 20;
  localparam int br_len    = 26;
  localparam int trap_len  = 8;
  localparam int total_len = alu_len + mem_len + br_len + trap_len;
  localparam int max_exp   = 256;

  logic        clk;
  logic        reset;
  logic        imem_we;
  logic [7:0]  imem_addr;
  logic [15:0] imem_data;
  logic        err;
  logic        halted;
  logic        wb_valid;
  logic [2:0]  wb_reg;
  logic [15:0] wb_data;

  logic [31:0] lfsr_state;
  logic [15:0] prog [64];
  int          prog_len;
  logic [2:0]  exp_reg [max_exp];
  logic [15:0] exp_data [max_exp];
  int          exp_count;
  int          exp_errs;
  int          head;
  logic        exp_avail;
  logic [2:0]  head_reg;
  logic [15:0] head_data;
  logic [15:0] model_regs [8];
  logic [15:0] model_mem [256];

  tb_clock clock0 (.clk(clk));

  proc DUT (
    .clk(clk), .reset(reset),
    .imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
    .err(err), .halted(halted),
    .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data)
  );

  bind proc proc_chk chk0 (
    .clk(clk), .reset(reset), .err(err), .halted(halted),
    .wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data),
    .exp_avail(tb_proc.exp_avail), .exp_reg(tb_proc.head_reg),
    .exp_data(tb_proc.head_data), .exp_errs(tb_proc.exp_errs)
  );

  // Head of the expected write list moves on each retire
  always @(posedge clk) begin
    if (reset)
      head <= 0;
    else if (wb_valid)
      head <= head + 1;
  end

  assign exp_avail = (head < exp_count);
  assign head_reg  = exp_reg[head[7:0]];
  assign head_data = exp_data[head[7:0]];

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | lfsr_state[0];
    end
    return v;
  endfunction

  function automatic logic [15:0] enc_r(input logic [4:0] op, input logic [2:0] rs,
                                        input logic [2:0] rt, input logic [2:0] rd);
    return {op, rs, rt, rd, 2'b00};
  endfunction

  function automatic logic [15:0] enc_i(input logic [4:0] op, input logic [2:0] rs,
                                        input logic [2:0] rt, input logic [4:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [15:0] enc_b(input logic [4:0] op, input logic [2:0] rs,
                                        input logic [7:0] disp);
    return {op, rs, disp};
  endfunction

  task automatic emit(input logic [15:0] w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  task automatic emit_filler();
    emit(enc_i(isa_pkg::op_addi, 3'(take_bits(3)), 3'(take_bits(3)), 5'(take_bits(5))));
  endtask

  // Random ALU mix, often reading the previous destination
  task automatic gen_alu();
    logic [2:0] last;
    logic [2:0] rs;
    logic [2:0] rt;
    logic [2:0] rd;
    int unsigned kind;
    prog_len = 0;
    last = 3'd1;
    emit(enc_i(isa_pkg::op_addi, 3'd0, 3'd1, 5'(take_bits(5))));
    while (prog_len < alu_len - 1) begin
      kind = take_bits(3) % 5;
      rs = 3'(take_bits(3));
      rt = 3'(take_bits(3));
      rd = 3'(take_bits(3));
      if (take_bits(1) != 0)
        rs = last;
      case (kind)
        0: emit(enc_r(isa_pkg::op_add, rs, rt, rd));
        1: emit(enc_r(isa_pkg::op_sub, rs, rt, rd));
        2: emit(enc_r(isa_pkg::op_and, rs, rt, rd));
        3: emit(enc_r(isa_pkg::op_xor, rs, rt, rd));
        default: emit(enc_i(isa_pkg::op_addi, rs, rd, 5'(take_bits(5))));
      endcase
      last = rd;
    end
    emit({isa_pkg::op_halt, 11'd0});
  endtask

  // Store then load at the same base and offset
  task automatic gen_mem();
    logic [2:0] d;
    logic [4:0] off;
    prog_len = 0;
    emit(enc_i(isa_pkg::op_addi, 3'd0, 3'd1, 5'(take_bits(5))));
    while (prog_len < mem_len - 1) begin
      d = 3'(2 + take_bits(3) % 6);
      off = 5'(take_bits(5));
      emit(enc_i(isa_pkg::op_addi, 3'd0, d, 5'(take_bits(5))));
      emit(enc_i(isa_pkg::op_st, 3'd1, d, off));
      emit(enc_i(isa_pkg::op_ld, 3'd1, 3'(take_bits(3)), off));
    end
    emit({isa_pkg::op_halt, 11'd0});
  endtask

  // Each branch skips the two fillers behind it when taken
  task automatic gen_branch();
    prog_len = 0;
    emit(enc_i(isa_pkg::op_addi, 3'd0, 3'd1, {1'b0, 4'(take_bits(4)) | 4'd1}));
    emit(enc_b(isa_pkg::op_beqz, 3'd0, 8'd2));
    emit_filler();
    emit_filler();
    emit(enc_b(isa_pkg::op_beqz, 3'd1, 8'd2));
    emit_filler();
    emit_filler();
    emit(enc_b(isa_pkg::op_j, 3'd0, 8'd2));
    emit_filler();
    emit_filler();
    while (prog_len < br_len - 1) begin
      if (take_bits(1) != 0)
        emit(enc_b(isa_pkg::op_j, 3'(take_bits(3)), 8'd2));
      else
        emit(enc_b(isa_pkg::op_beqz, 3'(take_bits(3)), 8'd2));
      emit_filler();
      emit_filler();
    end
    emit({isa_pkg::op_halt, 11'd0});
  endtask

  // Illegal opcodes, then a halt with writes behind it
  task automatic gen_trap();
    prog_len = 0;
    emit(enc_i(isa_pkg::op_addi, 3'd0, 3'd3, 5'd5));
    emit({5'd31, 11'(take_bits(11))});
    emit(enc_i(isa_pkg::op_addi, 3'd3, 3'd4, 5'd1));
    emit({5'd20, 11'(take_bits(11))});
    emit(enc_r(isa_pkg::op_add, 3'd3, 3'd4, 3'd5));
    emit({isa_pkg::op_halt, 11'd0});
    emit(enc_i(isa_pkg::op_addi, 3'd0, 3'd6, 5'd7));
    emit(enc_i(isa_pkg::op_addi, 3'd0, 3'd7, 5'd7));
  endtask

  task automatic record_write(input logic [2:0] r, input logic [15:0] v);
    exp_reg[exp_count] = r;
    exp_data[exp_count] = v;
    exp_count++;
    if (r != 3'd0)
      model_regs[r] = v;
  endtask

  // In-order execution of the program as the ISA defines it
  task automatic run_model();
    int pc;
    int steps;
    bit done;
    logic [15:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] imm;
    logic [15:0] disp;
    for (int i = 0; i < 8; i++)
      model_regs[i] = '0;
    exp_count = 0;
    exp_errs = 0;
    pc = 0;
    steps = 0;
    done = 0;
    while (!done && steps < 1000) begin
      w = (pc < prog_len) ? prog[pc] : 16'h0000;
      a = model_regs[w[10:8]];
      b = model_regs[w[7:5]];
      imm = {{11{w[4]}}, w[4:0]};
      disp = {{8{w[7]}}, w[7:0]};
      pc++;
      steps++;
      case (w[15:11])
        isa_pkg::op_add:  record_write(w[4:2], a + b);
        isa_pkg::op_sub:  record_write(w[4:2], a - b);
        isa_pkg::op_and:  record_write(w[4:2], a & b);
        isa_pkg::op_xor:  record_write(w[4:2], a ^ b);
        isa_pkg::op_addi: record_write(w[7:5], a + imm);
        isa_pkg::op_ld:   record_write(w[7:5], model_mem[8'(a + imm)]);
        isa_pkg::op_st:   model_mem[8'(a + imm)] = b;
        isa_pkg::op_beqz: if (a == 16'd0) pc = pc + int'($signed(disp));
        isa_pkg::op_j:    pc = pc + int'($signed(disp));
        isa_pkg::op_halt: done = 1;
        isa_pkg::op_nop:  ;
        default:          exp_errs++;
      endcase
    end
  endtask

  // Load under reset, release it and wait for the halt
  task automatic run_program();
    int cycles;
    @(negedge clk);
    reset = 1'b1;
    run_model();
    cycles = 1;
    for (int i = 0; i < prog_len; i++) begin
      @(negedge clk);
      imem_we = 1'b1;
      imem_addr = 8'(i);
      imem_data = prog[i];
      cycles++;
    end
    @(negedge clk);
    imem_we = 1'b0;
    cycles++;
    while (cycles < 8) begin
      @(negedge clk);
      cycles++;
    end
    @(negedge clk);
    reset = 1'b0;
    while (!halted)
      @(negedge clk);
    repeat (10) @(negedge clk);
  endtask

  always @(negedge clk) begin
    if (DUT.chk0.fail_count != 0) begin
      $display("tests failed");
      $fatal(1, "A retire or control check failed");
    end
  end

  initial begin
    repeat (40 * total_len + 200) @(posedge clk);
    $display("tests failed");
    $fatal(1, "Timeout: the processor did not reach halt in time");
  end

  initial begin
    reset = 1'b1;
    imem_we = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    lfsr_state = 32'hd291_5980;
    exp_count = 0;
    exp_errs = 0;
    gen_alu();
    run_program();
    gen_mem();
    run_program();
    gen_branch();
    run_program();
    gen_trap();
    run_program();
    if (DUT.chk0.fail_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("tests failed");
      $fatal(1, "Checks failed during the run");
    end
  end

endmodule

`default_nettype wire

/* tb.f */
isa_pkg.sv
pipe_pkg.sv
fetch.sv
decode.sv
hazard_detection.sv
execute.sv
memory.sv
proc.sv
tb_clock.sv
proc_chk.sv
tb_proc.sv

/* Makefile */
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_proc
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
PASS_MSG   ?= all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
